// ==== rtl/asg_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// arbitrary signal generator configuration
// widths and fixed-point constants shared by the RTL and testbench
//////////////////////////////////////////////////////////////////////

`ifndef ASG_CFG_SVH
`define ASG_CFG_SVH

// read pointer fixed point
`define ASG_CWM 10                    // integer bits, also table address width
`define ASG_CWF 16                    // fraction bits
`define ASG_CW  (`ASG_CWM + `ASG_CWF) // full pointer width

// sample path
`define ASG_DW  14  // signed sample width
`define ASG_MW  16  // gain width
`define ASG_GF  14  // gain fraction bits, 1<<14 is unity

// control
`define ASG_EW  6   // external trigger lines
`define ASG_BNW 16  // burst repetition counter
`define ASG_AW  13  // apb address, bit 12 selects the table window

`endif

// ==== rtl/asg_lin.sv ====
//////////////////////////////////////////////////////////////////////
// linear output stage
// gain, offset, saturation and output enable on the table samples
//////////////////////////////////////////////////////////////////////

`include "asg_cfg.svh"

module asg_lin (
  input  logic                       bus,
  input  logic                       ctl_rst,
  input  asg_pkg::sample_t           din,
  input  logic                       din_vld,  // pointer rd_en, one cycle early
  input  logic signed [`ASG_MW-1:0]  cfg_mul,
  input  asg_pkg::sample_t           cfg_sum,
  input  logic                       cfg_ena,
  output asg_pkg::sample_t           dout,
  output logic                       dout_vld
);
  import asg_pkg::*;

  localparam int PW   = `ASG_DW + `ASG_MW;
  localparam int SMAX = 2**(`ASG_DW-1) - 1;
  localparam int SMIN = -(2**(`ASG_DW-1));

  logic              vld_d;  // aligned with din
  logic signed [PW-1:0] mul;
  logic signed [PW-1:0] sft;
  logic signed [PW:0]   sum;
  sample_t           sat;

  assign mul = din * cfg_mul;
  assign sft = mul >>> `ASG_GF;  // drop gain fraction
  assign sum = sft + cfg_sum;

  // clip to the signed sample range
  always_comb begin
    if (sum > SMAX)
      sat = {1'b0, {(`ASG_DW-1){1'b1}}};
    else if (sum < SMIN)
      sat = {1'b1, {(`ASG_DW-1){1'b0}}};
    else
      sat = sum[`ASG_DW-1:0];
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      vld_d    <= 1'b0;
      dout_vld <= 1'b0;
    end else begin
      vld_d    <= din_vld;  // table read latency
      dout_vld <= vld_d;
    end
  end

  always_ff @(posedge bus) begin
    dout <= cfg_ena ? sat : '0;  // disabled output is zero, valid still runs
  end

  // unity gain and zero offset pass the table sample through unchanged
  a_lin_unity: assert property (@(posedge bus) disable iff (ctl_rst)
    vld_d && cfg_ena && cfg_mul == (1 << `ASG_GF) && cfg_sum == 0
    |=> dout == $past(din));

endmodule : asg_lin

// ==== rtl/asg_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// arbitrary signal generator types
// event pulses, pointer FSM states and the sample word
//////////////////////////////////////////////////////////////////////

`include "asg_cfg.svh"

package asg_pkg;

  // signed DAC sample
  typedef logic signed [`ASG_DW-1:0] sample_t;

  // single cycle control events, bit order matches the control register
  typedef struct packed {
    logic trg;     // trigger, armed -> run
    logic stp;     // stop
    logic str;     // start, idle -> armed
    logic sw_rst;  // software reset of the generator
  } evn_t;

  // read pointer FSM
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ARMED = 2'd1,
    RUN   = 2'd2
  } ptr_state_t;

endpackage : asg_pkg

// ==== rtl/asg_ptr.sv ====
//////////////////////////////////////////////////////////////////////
// table read pointer
// fixed-point accumulator, idle/armed/run FSM and burst counters
//////////////////////////////////////////////////////////////////////

`include "asg_cfg.svh"

module asg_ptr (
  input  logic                  bus,
  input  logic                  ctl_rst,
  input  asg_pkg::evn_t         evn,
  // configuration
  input  logic [`ASG_CW-1:0]    cfg_siz,
  input  logic [`ASG_CW-1:0]    cfg_off,
  input  logic [`ASG_CW-1:0]    cfg_ste,
  input  logic                  cfg_ben,
  input  logic                  cfg_inf,
  input  logic [`ASG_CWM-1:0]   cfg_bdl,
  input  logic [`ASG_BNW-1:0]   cfg_bnm,
  // table read
  output logic                  rd_en,
  output logic [`ASG_CWM-1:0]   rd_addr,
  // status
  output asg_pkg::ptr_state_t   state,
  output logic                  evn_per,
  output logic                  evn_lst,
  output logic [`ASG_BNW-1:0]   bnm_done
);
  import asg_pkg::*;

  logic [`ASG_CW-1:0]   ptr;
  logic [`ASG_CW:0]     ptr_sum;  // extra carry bit
  logic [`ASG_CW:0]     ptr_wrp;
  logic                 wrap;
  logic [`ASG_CWM-1:0]  bln_cnt;  // samples in current burst
  logic                 bst_end;  // last sample of a burst
  logic                 bst_lst;  // last sample of the last burst

  assign rd_en   = (state == RUN);
  assign rd_addr = ptr[`ASG_CW-1:`ASG_CWF];  // integer part

  assign ptr_sum = ptr + cfg_ste;
  assign wrap    = ptr_sum >= {1'b0, cfg_siz};
  assign ptr_wrp = ptr_sum - {1'b0, cfg_siz};

  assign bst_end = cfg_ben && (bln_cnt == cfg_bdl - 1'b1);
  assign bst_lst = bst_end && !cfg_inf && (bnm_done + 1'b1 == cfg_bnm);

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      state    <= IDLE;
      ptr      <= '0;
      bln_cnt  <= '0;
      bnm_done <= '0;
      evn_per  <= 1'b0;
      evn_lst  <= 1'b0;
    end else begin
      evn_per <= 1'b0;
      evn_lst <= 1'b0;
      if (evn.sw_rst || evn.stp) begin
        state <= IDLE;
        if (evn.sw_rst)
          bnm_done <= '0;
      end else begin
        case (state)
          IDLE: begin
            if (evn.str)
              state <= ARMED;
          end
          ARMED: begin
            if (evn.trg) begin
              state    <= RUN;
              ptr      <= cfg_off;  // phase
              bln_cnt  <= '0;
              bnm_done <= '0;
            end
          end
          RUN: begin
            if (bst_end) begin
              ptr      <= cfg_off;  // next burst restarts at the phase
              bln_cnt  <= '0;
              bnm_done <= bnm_done + 1'b1;
              if (bst_lst) begin
                state   <= IDLE;
                evn_lst <= 1'b1;
              end
            end else begin
              bln_cnt <= bln_cnt + 1'b1;
              if (wrap) begin
                ptr     <= ptr_wrp[`ASG_CW-1:0];
                evn_per <= 1'b1;
              end else begin
                ptr <= ptr_sum[`ASG_CW-1:0];
              end
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // pointer integer part stays inside the table size while running
  a_ptr_range: assert property (@(posedge bus) disable iff (ctl_rst)
    state == RUN |-> {rd_addr, {`ASG_CWF{1'b0}}} < cfg_siz);

endmodule : asg_ptr

// ==== rtl/asg_regs.sv ====
//////////////////////////////////////////////////////////////////////
// generator register block
// APB slave with configuration, event masks, interrupts and the
// table write window
//////////////////////////////////////////////////////////////////////

`include "asg_cfg.svh"

module asg_regs (
  input  logic                      bus,
  input  logic                      ctl_rst,
  // apb slave
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`ASG_AW-1:0]        paddr,
  input  logic [32-1:0]             pwdata,
  output logic [32-1:0]             prdata,
  output logic                      pready,
  output logic                      pslverr,
  // events and pointer status
  input  logic [`ASG_EW-1:0]        trig_ext,
  output asg_pkg::evn_t             evn,
  input  asg_pkg::ptr_state_t       state,
  input  logic                      evn_per,
  input  logic                      evn_lst,
  input  logic [`ASG_BNW-1:0]       bnm_done,
  output logic                      irq,
  // table write
  output logic                      tbl_we,
  output logic [`ASG_CWM-1:0]       tbl_waddr,
  output asg_pkg::sample_t          tbl_wdata,
  // configuration
  output logic [`ASG_CW-1:0]        cfg_siz,
  output logic [`ASG_CW-1:0]        cfg_off,
  output logic [`ASG_CW-1:0]        cfg_ste,
  output logic                      cfg_ben,
  output logic                      cfg_inf,
  output logic [`ASG_CWM-1:0]       cfg_bdl,
  output logic [`ASG_BNW-1:0]       cfg_bnm,
  output logic signed [`ASG_MW-1:0] cfg_mul,
  output asg_pkg::sample_t          cfg_sum,
  output logic                      cfg_ena
);
  import asg_pkg::*;

  logic                acc;      // access phase
  logic                wr;       // register write
  logic [12-1:0]       adr;      // register offset
  evn_t                ctl;      // software pulses from 0x00
  logic [`ASG_EW-1:0]  msk_str;
  logic [`ASG_EW-1:0]  msk_stp;
  logic [`ASG_EW-1:0]  msk_trg;
  logic [`ASG_EW-1:0]  trg_d;    // previous trigger lines
  logic [`ASG_EW-1:0]  trg_edg;  // rising edges
  logic [4-1:0]        irq_ena;
  logic [4-1:0]        irq_sts;
  logic [4-1:0]        irq_set;
  logic                sts_per;  // sticky wrap seen

  //////////////////////////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////////////////////////

  assign acc     = psel & penable;
  assign pready  = acc;   // no wait states
  assign pslverr = 1'b0;
  assign adr     = paddr[12-1:0];
  assign wr      = acc & pwrite & ~paddr[12];

  // table window, word index in 11:2
  assign tbl_we    = acc & pwrite & paddr[12];
  assign tbl_waddr = paddr[`ASG_CWM+1:2];
  assign tbl_wdata = pwdata[`ASG_DW-1:0];

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq_ena <= '0;
      msk_str <= '0;
      msk_stp <= '0;
      msk_trg <= '0;
      cfg_siz <= '0;
      cfg_off <= '0;
      cfg_ste <= '0;
      cfg_ben <= 1'b0;
      cfg_inf <= 1'b0;
      cfg_bdl <= '0;
      cfg_bnm <= '0;
      cfg_mul <= '0;
      cfg_sum <= '0;
      cfg_ena <= 1'b0;
    end else if (wr) begin
      case (adr)
        'h08: irq_ena <= pwdata[4-1:0];
        'h10: msk_str <= pwdata[`ASG_EW-1:0];
        'h14: msk_stp <= pwdata[`ASG_EW-1:0];
        'h18: msk_trg <= pwdata[`ASG_EW-1:0];
        'h20: cfg_siz <= pwdata[`ASG_CW-1:0];
        'h24: cfg_off <= pwdata[`ASG_CW-1:0];
        'h28: cfg_ste <= pwdata[`ASG_CW-1:0];
        'h30: begin
          cfg_ben <= pwdata[0];
          cfg_inf <= pwdata[1];
        end
        'h34: cfg_bdl <= pwdata[`ASG_CWM-1:0];
        'h3c: cfg_bnm <= pwdata[`ASG_BNW-1:0];
        'h50: cfg_mul <= pwdata[`ASG_MW-1:0];
        'h54: cfg_sum <= pwdata[`ASG_DW-1:0];
        'h58: cfg_ena <= pwdata[0];
        default: ;
      endcase
    end
  end

  // read mux, table reads give zero
  always_comb begin
    prdata = '0;
    if (!paddr[12]) begin
      case (adr)
        'h00: begin
          prdata[1:0] = state;
          prdata[4]   = sts_per;
        end
        'h08: prdata[4-1:0]        = irq_ena;
        'h0c: prdata[4-1:0]        = irq_sts;
        'h10: prdata[`ASG_EW-1:0]  = msk_str;
        'h14: prdata[`ASG_EW-1:0]  = msk_stp;
        'h18: prdata[`ASG_EW-1:0]  = msk_trg;
        'h20: prdata[`ASG_CW-1:0]  = cfg_siz;
        'h24: prdata[`ASG_CW-1:0]  = cfg_off;
        'h28: prdata[`ASG_CW-1:0]  = cfg_ste;
        'h30: prdata[1:0]          = {cfg_inf, cfg_ben};
        'h34: prdata[`ASG_CWM-1:0] = cfg_bdl;
        'h3c: prdata[`ASG_BNW-1:0] = cfg_bnm;
        'h44: prdata[`ASG_BNW-1:0] = bnm_done;
        'h50: prdata[`ASG_MW-1:0]  = cfg_mul;
        'h54: prdata[`ASG_DW-1:0]  = cfg_sum;
        'h58: prdata[0]            = cfg_ena;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // events and interrupts
  //////////////////////////////////////////////////////////////////////

  assign ctl     = (wr && adr == 'h00) ? evn_t'(pwdata[4-1:0]) : '0;
  assign trg_edg = trig_ext & ~trg_d;
  assign irq_set = {evn_lst, evn.trg, evn.stp, evn.str};

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      trg_d <= '0;
      evn   <= '0;
    end else begin
      trg_d      <= trig_ext;
      evn.sw_rst <= ctl.sw_rst;                      // software only
      evn.str    <= ctl.str | (|(trg_edg & msk_str));
      evn.stp    <= ctl.stp | (|(trg_edg & msk_stp));
      evn.trg    <= ctl.trg | (|(trg_edg & msk_trg));
    end
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq_sts <= '0;
      sts_per <= 1'b0;
      irq     <= 1'b0;
    end else begin
      if (evn.sw_rst) begin
        irq_sts <= '0;
        sts_per <= 1'b0;
      end else begin
        if (wr && adr == 'h0c)
          irq_sts <= (irq_sts & ~pwdata[4-1:0]) | irq_set;  // w1c, new events win
        else
          irq_sts <= irq_sts | irq_set;
        sts_per <= sts_per | evn_per;
      end
      irq <= |(irq_sts & irq_ena);  // one cycle behind status
    end
  end

  // setup phase holds its address and direction into the access phase
  a_apb_stable: assert property (@(posedge bus) disable iff (ctl_rst)
    psel && !penable |=> penable && $stable(pwrite) && $stable(paddr));

endmodule : asg_regs

// ==== rtl/asg_table.sv ====
//////////////////////////////////////////////////////////////////////
// waveform table
// one write port from the bus, registered read port for the pointer
//////////////////////////////////////////////////////////////////////

`include "asg_cfg.svh"

module asg_table (
  input  logic                 bus,
  // bus write
  input  logic                 we,
  input  logic [`ASG_CWM-1:0]  waddr,
  input  asg_pkg::sample_t     wdata,
  // pointer read
  input  logic                 rd_en,
  input  logic [`ASG_CWM-1:0]  rd_addr,
  output asg_pkg::sample_t     rd_data
);
  import asg_pkg::*;

  sample_t mem [2**`ASG_CWM];  // contents only from software

  always_ff @(posedge bus) begin
    if (we)
      mem[waddr] <= wdata;
  end

  // one cycle read latency
  always_ff @(posedge bus) begin
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

endmodule : asg_table

// ==== rtl/asg_top.sv ====
//////////////////////////////////////////////////////////////////////
// arbitrary signal generator, one channel
// APB register block, read pointer, waveform table, linear stage
//////////////////////////////////////////////////////////////////////

`include "asg_cfg.svh"

module asg_top (
  input  logic                 bus,
  input  logic                 ctl_rst,
  // apb slave
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [`ASG_AW-1:0]   paddr,
  input  logic [32-1:0]        pwdata,
  output logic [32-1:0]        prdata,
  output logic                 pready,
  output logic                 pslverr,
  // external trigger lines
  input  logic [`ASG_EW-1:0]   trig_ext,
  output logic                 irq,
  // DAC stream
  output asg_pkg::sample_t     dout,
  output logic                 dout_vld
);
  import asg_pkg::*;

  evn_t                     evn;
  ptr_state_t               state;
  logic                     evn_per;
  logic                     evn_lst;
  logic [`ASG_BNW-1:0]      bnm_done;
  // table write
  logic                     tbl_we;
  logic [`ASG_CWM-1:0]      tbl_waddr;
  sample_t                  tbl_wdata;
  // table read
  logic                     rd_en;
  logic [`ASG_CWM-1:0]      rd_addr;
  sample_t                  rd_data;
  // configuration
  logic [`ASG_CW-1:0]       cfg_siz;
  logic [`ASG_CW-1:0]       cfg_off;
  logic [`ASG_CW-1:0]       cfg_ste;
  logic                     cfg_ben;
  logic                     cfg_inf;
  logic [`ASG_CWM-1:0]      cfg_bdl;
  logic [`ASG_BNW-1:0]      cfg_bnm;
  logic signed [`ASG_MW-1:0] cfg_mul;
  sample_t                  cfg_sum;
  logic                     cfg_ena;

  asg_regs regs_i (
    .bus, .ctl_rst,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .trig_ext, .evn, .state, .evn_per, .evn_lst, .bnm_done, .irq,
    .tbl_we, .tbl_waddr, .tbl_wdata,
    .cfg_siz, .cfg_off, .cfg_ste, .cfg_ben, .cfg_inf, .cfg_bdl, .cfg_bnm,
    .cfg_mul, .cfg_sum, .cfg_ena
  );

  asg_ptr ptr_i (
    .bus, .ctl_rst, .evn,
    .cfg_siz, .cfg_off, .cfg_ste, .cfg_ben, .cfg_inf, .cfg_bdl, .cfg_bnm,
    .rd_en, .rd_addr, .state, .evn_per, .evn_lst, .bnm_done
  );

  asg_table table_i (
    .bus,
    .we      (tbl_we),
    .waddr   (tbl_waddr),
    .wdata   (tbl_wdata),
    .rd_en, .rd_addr, .rd_data
  );

  // valid is rd_en, delayed inside the stage
  asg_lin lin_i (
    .bus, .ctl_rst,
    .din     (rd_data),
    .din_vld (rd_en),
    .cfg_mul, .cfg_sum, .cfg_ena,
    .dout, .dout_vld
  );

endmodule : asg_top

// ==== sim.f ====
+incdir+rtl
rtl/asg_pkg.sv
rtl/asg_regs.sv
rtl/asg_table.sv
rtl/asg_ptr.sv
rtl/asg_lin.sv
rtl/asg_top.sv
verif/asg_tb.sv

// ==== verif/asg_tb.sv ====
//////////////////////////////////////////////////////////////////////
// generator testbench
// APB stimulus, reference sample model, DAC stream monitor and
// in-order comparison over six tests
//////////////////////////////////////////////////////////////////////

`include "asg_cfg.svh"

module asg_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import asg_pkg::*;

  typedef int smp_q_t[$];

  localparam int ONE     = 1 << `ASG_CWF;  // pointer value 1.0
  localparam int UNITY   = 1 << `ASG_GF;   // gain 1.0
  localparam int MAX_CYC = 6000;           // six tests of up to ~700 cycles plus margin

  logic                bus;
  logic                ctl_rst;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [`ASG_AW-1:0]  paddr;
  logic [32-1:0]       pwdata;
  logic [32-1:0]       prdata;
  logic                pready;
  logic                pslverr;
  logic [`ASG_EW-1:0]  trig_ext;
  logic                irq;
  sample_t             dout;
  logic                dout_vld;

  int     tbl_copy [2**`ASG_CWM];  // what software wrote to the table
  int     got_q[$];                // samples seen on the stream
  int     cyc;
  int     test_errs;
  int     pass_cnt;
  int     fail_cnt;
  string  cur_test;
  // generator settings as last written
  longint m_siz, m_off, m_ste;
  bit     m_ben, m_inf;
  int     m_bdl, m_bnm, m_mul, m_sum;
  bit     m_ena;

  asg_top dut_i (
    .bus, .ctl_rst,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .trig_ext, .irq, .dout, .dout_vld
  );

  always #2 bus = ~bus;  // 4 ns period

  // global run limit
  always @(posedge bus) begin
    cyc = cyc + 1;
    if (cyc >= MAX_CYC) begin
      $display("timeout after %0d cycles, run stopped", cyc);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // stream monitor at mid cycle
  always @(negedge bus) begin
    if (dout_vld === 1'b1)
      got_q.push_back(int'(dout));
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // gain, shift, offset, clip, enable
  function automatic int lin_ref(input int din);
    longint p;
    p = longint'(din) * m_mul;
    p = p >>> `ASG_GF;
    p = p + m_sum;
    if (p > (2**(`ASG_DW-1) - 1))
      p = 2**(`ASG_DW-1) - 1;
    else if (p < -(2**(`ASG_DW-1)))
      p = -(2**(`ASG_DW-1));
    if (!m_ena)
      return 0;
    return int'(p);
  endfunction

  // expected stream of at most n samples
  function automatic smp_q_t model_samples(input int n);
    smp_q_t q;
    longint ptr;
    int     rep;
    int     k;
    ptr = m_off;
    rep = 0;
    if (!m_ben) begin
      while (q.size() < n) begin
        q.push_back(lin_ref(tbl_copy[int'(ptr >> `ASG_CWF)]));
        ptr = ptr + m_ste;
        if (ptr >= m_siz)
          ptr = ptr - m_siz;  // wrap at table size
      end
    end else begin
      while (q.size() < n && (m_inf || rep < m_bnm)) begin
        ptr = m_off;          // each burst restarts at the phase
        for (k = 0; k < m_bdl && q.size() < n; k++) begin
          q.push_back(lin_ref(tbl_copy[int'(ptr >> `ASG_CWF)]));
          ptr = ptr + m_ste;
          if (ptr >= m_siz)
            ptr = ptr - m_siz;
        end
        rep++;
      end
    end
    return q;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // bus and check tasks
  //////////////////////////////////////////////////////////////////////

  task automatic note_fail(input string msg);
    $display("%s: %s", cur_test, msg);
    test_errs++;
  endtask

  task automatic check_val(input string what, input longint exp, input longint act);
    assert (exp == act) else begin
      $display("ERR %s exp %0d act %0d  %s", cur_test, exp, act, what);
      test_errs++;
    end
  endtask

  task automatic apb_write(input logic [`ASG_AW-1:0] addr, input logic [31:0] data);
    @(posedge bus);
    #1;
    psel    = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge bus);
    #1;
    penable = 1'b1;  // access phase
    @(negedge bus);
    assert (pready === 1'b1 && pslverr === 1'b0)
      else note_fail("write access without pready or with pslverr");
    @(posedge bus);  // write lands here
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [`ASG_AW-1:0] addr, output logic [31:0] data);
    @(posedge bus);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge bus);
    #1;
    penable = 1'b1;
    @(negedge bus);
    assert (pready === 1'b1 && pslverr === 1'b0)
      else note_fail("read access without pready or with pslverr");
    data = prdata;   // combinational read data
    @(posedge bus);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic load_table(input int n);
    int v;
    for (int i = 0; i < n; i++) begin
      v = $urandom % (1 << `ASG_DW);
      tbl_copy[i] = (v >= (1 << (`ASG_DW-1))) ? v - (1 << `ASG_DW) : v;
      apb_write(13'h1000 | (i << 2), v);  // table window
    end
  endtask

  task automatic setup_gen(input longint siz, input longint off, input longint ste,
                           input bit ben, input bit inf, input int bdl, input int bnm,
                           input int mul, input int sum, input bit ena);
    m_siz = siz;
    m_off = off;
    m_ste = ste;
    m_ben = ben;
    m_inf = inf;
    m_bdl = bdl;
    m_bnm = bnm;
    m_mul = mul;
    m_sum = sum;
    m_ena = ena;
    apb_write('h20, siz);
    apb_write('h24, off);
    apb_write('h28, ste);
    apb_write('h30, {inf, ben});
    apb_write('h34, bdl);
    apb_write('h3c, bnm);
    apb_write('h50, mul);
    apb_write('h54, sum);
    apb_write('h58, ena);
  endtask

  task automatic set_masks(input int str, input int stp, input int trg);
    apb_write('h10, str);
    apb_write('h14, stp);
    apb_write('h18, trg);
  endtask

  task automatic sw_start();
    apb_write('h00, 32'h2);  // str moves idle to armed
    apb_write('h00, 32'h8);  // trg moves armed to run
  endtask

  task automatic wait_samples(input int n, input int limit);
    int k;
    k = 0;
    while (got_q.size() < n && k < limit) begin
      @(posedge bus);
      k++;
    end
    assert (got_q.size() >= n)
      else note_fail($sformatf("only %0d of %0d samples arrived", got_q.size(), n));
  endtask

  // software stop and a quiet stream after it
  task automatic stop_and_settle();
    int n;
    apb_write('h00, 32'h4);
    repeat (6) @(posedge bus);
    #1;
    assert (dout_vld === 1'b0) else note_fail("dout_vld still high after stop");
    n = got_q.size();
    repeat (20) @(posedge bus);
    assert (got_q.size() == n) else note_fail("samples arrived after stop");
  endtask

  task automatic compare_samples(input smp_q_t exp);
    for (int i = 0; i < exp.size() && i < got_q.size(); i++)
      check_val($sformatf("sample %0d", i), exp[i], got_q[i]);
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
    apb_write('h00, 32'h1);  // sw_rst returns to idle
    repeat (4) @(posedge bus);
    got_q.delete();
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %s passed", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d errors", cur_test, test_errs);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic reg_readback();
    logic [`ASG_AW-1:0] adr_l [13];
    logic [31:0]        msk_l [13];
    logic [31:0]        d;
    logic [31:0]        w;
    adr_l = '{'h08, 'h10, 'h14, 'h18, 'h20, 'h24, 'h28, 'h30, 'h34, 'h3c,
              'h50, 'h54, 'h58};
    msk_l = '{'hf, 'h3f, 'h3f, 'h3f, 'h3ff_ffff, 'h3ff_ffff, 'h3ff_ffff, 'h3,
              'h3ff, 'hffff, 'hffff, 'h3fff, 'h1};
    cur_test  = "regs";
    test_errs = 0;
    assert (irq === 1'b0 && dout_vld === 1'b0) else note_fail("outputs not low after reset");
    apb_read('h0c, d);
    check_val("irq status after reset", 0, d);
    apb_read('h00, d);
    check_val("state after reset", 0, d);
    foreach (adr_l[i]) begin
      w = $urandom;
      apb_write(adr_l[i], w);
      apb_read(adr_l[i], d);
      check_val($sformatf("reg 0x%0h", adr_l[i]), w & msk_l[i], d);
    end
    end_test();
  endtask

  task automatic continuous_playback();
    logic [31:0] d;
    begin_test("cont");
    set_masks(0, 0, 0);
    load_table(64);
    setup_gen(64 * ONE, 5 * ONE, ONE, 0, 0, 0, 0, UNITY, 0, 1);
    sw_start();
    wait_samples(200, 400);
    stop_and_settle();
    compare_samples(model_samples(got_q.size()));  // wraps past entry 63
    apb_read('h00, d);
    check_val("state after stop", 0, d[1:0]);
    check_val("wrap flag", 1, d[4]);
    end_test();
  endtask

  task automatic fractional_scaling();
    begin_test("frac");
    setup_gen(64 * ONE, 'h2_8000, 'h0_c000, 0, 0, 0, 0, 'h6000, 3000, 1);  // step 0.75 and gain 1.5
    sw_start();
    wait_samples(150, 300);
    stop_and_settle();
    compare_samples(model_samples(got_q.size()));
    // disabled output streams zeros
    got_q.delete();
    m_ena = 0;
    apb_write('h58, 0);
    sw_start();
    wait_samples(50, 150);
    stop_and_settle();
    compare_samples(model_samples(got_q.size()));
    end_test();
  endtask

  task automatic burst_playback();
    logic [31:0] d;
    begin_test("burst");
    apb_write('h0c, 32'hf);  // clear old status
    apb_write('h08, 32'h8);  // last burst only
    setup_gen(64 * ONE, 10 * ONE, 'h1_8000, 1, 0, 20, 3, UNITY, 0, 1);
    sw_start();
    assert (irq === 1'b0) else note_fail("irq high before the last burst");
    wait_samples(60, 200);
    repeat (20) @(posedge bus);
    check_val("sample count", 20 * 3, got_q.size());
    compare_samples(model_samples(1000));  // model ends by itself
    apb_read('h44, d);
    check_val("bursts done", 3, d);
    check_val("irq", 1, irq);
    end_test();
  endtask

  task automatic pulse_line(input int line);
    @(posedge bus);
    #1;
    trig_ext[line] = 1'b1;
    repeat (2) @(posedge bus);
    #1;
    trig_ext = '0;
  endtask

  task automatic external_trigger();
    logic [31:0] d;
    begin_test("ext_trg");
    apb_write('h0c, 32'hf);
    apb_write('h08, 32'h0);
    set_masks(0, 0, 'h04);  // trigger from line 2 only
    setup_gen(30 * ONE, 'h3_8000, 'h1_4000, 1, 0, 25, 2, UNITY, -100, 1);
    apb_write('h00, 32'h2);
    apb_read('h00, d);
    check_val("state after start", 1, d[1:0]);
    pulse_line(4);           // not selected
    repeat (10) @(posedge bus);
    assert (got_q.size() == 0) else note_fail("samples after pulse on an unselected line");
    apb_read('h00, d);
    check_val("state after line 4", 1, d[1:0]);
    pulse_line(2);
    wait_samples(50, 200);
    repeat (20) @(posedge bus);
    check_val("sample count", 25 * 2, got_q.size());
    compare_samples(model_samples(1000));
    end_test();
  endtask

  task automatic interrupt_clear();
    logic [31:0] d;
    begin_test("irq_clr");
    apb_write('h30, 32'h0);
    apb_write('h0c, 32'hf);
    apb_write('h08, 32'h5);  // start and trigger enabled
    sw_start();
    apb_write('h00, 32'h4);
    repeat (4) @(posedge bus);
    apb_read('h0c, d);
    check_val("status after run", 7, d);
    check_val("irq set", 1, irq);
    apb_write('h0c, 32'h1);  // clear start
    repeat (2) @(posedge bus);
    #1;
    apb_read('h0c, d);
    check_val("status after start clear", 6, d);
    check_val("irq with trigger left", 1, irq);
    apb_write('h0c, 32'h4);  // clear trigger
    repeat (2) @(posedge bus);
    #1;
    apb_read('h0c, d);
    check_val("status after trigger clear", 2, d);  // stop not enabled
    check_val("irq cleared", 0, irq);
    repeat (10) @(posedge bus);
    got_q.delete();
    end_test();
  endtask

  initial begin
    bus      = 1'b0;
    ctl_rst  = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    trig_ext = '0;
    cyc      = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    void'($urandom(78));
    repeat (5) @(posedge bus);
    #1;
    ctl_rst = 1'b0;
    reg_readback();
    continuous_playback();
    fractional_scaling();
    burst_playback();
    external_trigger();
    interrupt_clear();
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule : asg_tb
